// ==== kmac_pkg.sv ====
/*
  KMAC error checker package
  Shared command, mode, strength and error-code encodings, the error
  record handed from the checker to the error register, and the encoded
  KMAC function-name prefix
*/
package kmac_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Software commands
  //////////////////////////////////////////////////////////////////////////

  // Sparse 6-bit command codes, CmdNone means no strobe this cycle
  typedef enum logic [5:0] {
    CmdNone      = 6'h00,
    CmdStart     = 6'h1D,
    CmdProcess   = 6'h2E,
    CmdManualRun = 6'h31,
    CmdDone      = 6'h16
  } kmac_cmd_e;

  //////////////////////////////////////////////////////////////////////////
  // Hash configuration
  //////////////////////////////////////////////////////////////////////////

  // Hash mode, code 1 is reserved
  typedef enum logic [1:0] {
    Sha3   = 2'd0,
    Shake  = 2'd2,
    CShake = 2'd3
  } sha3_mode_e;

  // Security strength in bits
  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  // First six bytes of the function-name prefix
  typedef logic [47:0] prefix_t;

  // encode_string("KMAC"), left_encode(32) followed by the four characters
  parameter prefix_t EncodedStringKMAC = 48'h4341_4D4B_2001;

  // Permutation round counter
  typedef logic [4:0] round_cnt_t;

  //////////////////////////////////////////////////////////////////////////
  // Error reporting
  //////////////////////////////////////////////////////////////////////////

  // Error codes as seen by software
  typedef enum logic [7:0] {
    ErrNone                         = 8'h00,
    ErrUnexpectedModeStrength       = 8'h06,
    ErrIncorrectFunctionName        = 8'h07,
    ErrSwCmdSequence                = 8'h08,
    ErrSwHashingWithoutEntropyReady = 8'h09
  } err_code_e;

  // Diagnostic payload, layout depends on the code
  typedef logic [23:0] err_info_t;

  typedef struct packed {
    logic      valid;
    err_code_e code;
    err_info_t info;
  } err_t;

endpackage : kmac_pkg

// ==== kmac_errchk.sv ====
/*
  KMAC software error checker
  Tracks the Start, Process, absorbed, ManualRun/Done command sequence in
  a sparsely encoded FSM and checks the configuration at Start. Commands
  that break the sequence or carry a fatal configuration are held back
  from the registered command output.
*/
module kmac_errchk
  import kmac_pkg::*;
#(
  parameter bit EnMasking = 1'b1
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Configuration sampled at Start
  input  sha3_mode_e       cfg_mode_i,
  input  keccak_strength_e cfg_strength_i,
  input  logic             kmac_en_i,
  input  prefix_t          cfg_prefix_i,
  input  logic             cfg_en_unsupported_modestrength_i,
  input  logic             entropy_ready_pulse_i,

  // Software command strobe and its filtered, registered copy
  input  kmac_cmd_e        sw_cmd_i,
  output kmac_cmd_e        sw_cmd_o,

  // Engine status
  input  logic             app_active_i,
  input  logic             absorbed_i,
  input  logic             keccak_done_i,

  input  logic             escalate_i,
  input  logic             err_processed_i,
  input  logic             clear_after_error_i,

  output err_t             error_o,
  output logic             sparse_fsm_error_o
);

  ////////////////////////////////////////////////////////////////////////////
  // State encoding
  ////////////////////////////////////////////////////////////////////////////

  // Minimum Hamming distance of 3 between any two states
  typedef enum logic [5:0] {
    StIdle          = 6'b001101,
    StMsgFeed       = 6'b110001,
    StProcessing    = 6'b010110,
    StAbsorbed      = 6'b100010,
    StSqueezing     = 6'b111100,
    StTerminalError = 6'b011011
  } st_e;

  // Compact state code reported in the error info field
  typedef enum logic [2:0] {
    StIdleL,
    StMsgFeedL,
    StProcessingL,
    StAbsorbedL,
    StSqueezingL,
    StErrorL
  } st_logical_e;

  st_e         st_q;
  st_e         st_d;
  st_e         st_gated_d;
  st_logical_e st_l;

  logic start_go;
  logic mode_strength_ok;
  logic err_swsequence;
  logic err_modestrength;
  logic err_prefix;
  logic err_entropy_ready;
  logic cfg_entropy_ready;
  logic block_swcmd;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Idle to MsgFeed, the only point where configuration is checked
  assign start_go = (st_q == StIdle) && !app_active_i && (sw_cmd_i == CmdStart);

  // Allowed commands per state
  always_comb begin
    err_swsequence     = 1'b0;
    sparse_fsm_error_o = 1'b0;
    case (st_q)
      StIdle:       err_swsequence = !(sw_cmd_i inside {CmdNone, CmdStart});
      StMsgFeed:    err_swsequence = !(sw_cmd_i inside {CmdNone, CmdProcess});
      StProcessing: err_swsequence = (sw_cmd_i != CmdNone);
      StAbsorbed: begin
        err_swsequence = !(sw_cmd_i inside {CmdNone, CmdManualRun, CmdDone});
      end
      StSqueezing:  err_swsequence = (sw_cmd_i != CmdNone);
      // Terminal and unknown codes both flag the FSM
      default:      sparse_fsm_error_o = 1'b1;
    endcase
  end

  // Sha3 takes L224 and up, the XOFs only L128 or L256
  assign mode_strength_ok =
      ((cfg_mode_i == Sha3) && (cfg_strength_i inside {L224, L256, L384, L512})) ||
      ((cfg_mode_i inside {Shake, CShake}) && (cfg_strength_i inside {L128, L256}));

  assign err_modestrength = start_go && !mode_strength_ok;
  assign err_prefix       = start_go && kmac_en_i && (cfg_prefix_i != EncodedStringKMAC);

  // Entropy ready arrives as a pulse, remember it until the error is handled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_entropy_ready <= 1'b0;
    end else if (err_processed_i) begin
      cfg_entropy_ready <= 1'b0;
    end else if (entropy_ready_pulse_i && (st_q == StIdle)) begin
      cfg_entropy_ready <= 1'b1;
    end
  end

  // Only a masked engine needs entropy before a KMAC run
  assign err_entropy_ready = EnMasking && start_go && kmac_en_i && !cfg_entropy_ready;

  // Prefix errors are reported but let the command through
  assign block_swcmd = err_swsequence ||
                       (err_modestrength && !cfg_en_unsupported_modestrength_i) ||
                       err_entropy_ready;

  // Command register, a blocked command never reaches the engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sw_cmd_o <= CmdNone;
    end else if (!block_swcmd) begin
      sw_cmd_o <= sw_cmd_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error code
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (st_q)
      StIdle:       st_l = StIdleL;
      StMsgFeed:    st_l = StMsgFeedL;
      StProcessing: st_l = StProcessingL;
      StAbsorbed:   st_l = StAbsorbedL;
      StSqueezing:  st_l = StSqueezingL;
      default:      st_l = StErrorL;
    endcase
  end

  // Highest priority first
  always_comb begin
    error_o = '{valid: 1'b0, code: ErrNone, info: '0};
    if (err_swsequence) begin
      // Flags, logical state, received command
      error_o.valid = 1'b1;
      error_o.code  = ErrSwCmdSequence;
      error_o.info  = {5'h0, err_swsequence, err_modestrength, err_prefix,
                       5'h0, st_l, 2'b00, sw_cmd_i};
    end else if (err_modestrength) begin
      // Flags, then mode and strength in the low byte
      error_o.valid = 1'b1;
      error_o.code  = ErrUnexpectedModeStrength;
      error_o.info  = {5'h0, err_swsequence, err_modestrength, err_prefix,
                       8'h00, 2'b00, cfg_mode_i, 1'b0, cfg_strength_i};
    end else if (err_prefix) begin
      error_o.valid = 1'b1;
      error_o.code  = ErrIncorrectFunctionName;
      error_o.info  = {5'h0, err_swsequence, err_modestrength, err_prefix, 16'h0000};
    end else if (err_entropy_ready) begin
      error_o.valid = 1'b1;
      error_o.code  = ErrSwHashingWithoutEntropyReady;
      error_o.info  = {4'h0, err_entropy_ready, err_swsequence, err_modestrength,
                       err_prefix, 14'h0000, kmac_en_i, cfg_entropy_ready};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    st_d = st_q;
    case (st_q)
      StIdle: begin
        if (start_go)
          st_d = StMsgFeed;
      end
      StMsgFeed: begin
        if (sw_cmd_i == CmdProcess)
          st_d = StProcessing;
      end
      // Wait for the permutation to finish absorbing
      StProcessing: begin
        if (absorbed_i)
          st_d = StAbsorbed;
      end
      StAbsorbed: begin
        if (sw_cmd_i == CmdManualRun) begin
          st_d = StSqueezing;
        end else if (sw_cmd_i == CmdDone) begin
          st_d = StIdle;
        end
      end
      StSqueezing: begin
        if (keccak_done_i)
          st_d = StAbsorbed;
      end
      StTerminalError: st_d = StTerminalError;
      // Corrupted encoding
      default:         st_d = StTerminalError;
    endcase

    // Software recovery, never out of the terminal state
    if (clear_after_error_i && (st_d != StTerminalError))
      st_d = StIdle;
  end

  // A blocked command leaves the state untouched
  assign st_gated_d = block_swcmd ? st_q : st_d;

  // Escalation wins over everything
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= StIdle;
    end else if (escalate_i) begin
      st_q <= StTerminalError;
    end else begin
      st_q <= st_gated_d;
    end
  end

  StKnown_A: assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(st_q))
    else $error("Checker state is unknown");

  // Once the FSM is broken, no software error may be raised on top of it
  FsmErrNoSwErr_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sparse_fsm_error_o |-> !error_o.valid)
    else $error("Software error raised in terminal state");

endmodule : kmac_errchk

// ==== sha3_round_ctrl.sv ====
/*
  SHA3 round controller
  Stands in for the Keccak permutation. Process starts an absorb run and
  ManualRun a squeeze run; after NumRounds cycles the matching one-cycle
  pulse goes back to the checker.
*/
module sha3_round_ctrl
  import kmac_pkg::*;
#(
  parameter int NumRounds = 24
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Registered, already filtered command
  input  kmac_cmd_e sw_cmd_i,

  output logic      absorbed_o,
  output logic      done_o
);

  typedef enum logic [1:0] {
    RndIdle,
    RndAbsorb,
    RndSqueeze
  } rnd_st_e;

  // Last round index, the pulse follows on the next cycle
  localparam round_cnt_t LastRound = round_cnt_t'(NumRounds - 1);

  rnd_st_e    st_q;
  round_cnt_t round_q;
  logic       last_round;

  assign last_round = (round_q == LastRound);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= RndIdle;
      round_q    <= '0;
      absorbed_o <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      // Pulses last a single cycle
      absorbed_o <= 1'b0;
      done_o     <= 1'b0;
      case (st_q)
        RndIdle: begin
          round_q <= '0;
          if (sw_cmd_i == CmdProcess) begin
            st_q <= RndAbsorb;
          end else if (sw_cmd_i == CmdManualRun) begin
            st_q <= RndSqueeze;
          end
        end
        RndAbsorb, RndSqueeze: begin
          round_q <= round_q + 1'b1;
          if (last_round) begin
            absorbed_o <= (st_q == RndAbsorb);
            done_o     <= (st_q == RndSqueeze);
            st_q       <= RndIdle;
          end
        end
        default: st_q <= RndIdle;
      endcase
    end
  end

  // Absorb and squeeze runs never overlap
  PulseOneHot_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(absorbed_o && done_o))
    else $error("Absorbed and done pulsed together");

endmodule : sha3_round_ctrl

// ==== kmac_err_reg.sv ====
/*
  KMAC error register
  Holds the first reported error until software acknowledges it and
  counts, with saturation, the errors that arrive in the meantime
*/
module kmac_err_reg
  import kmac_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  err_t       error_i,
  input  logic       err_processed_i,

  output err_t       err_o,
  output logic [3:0] err_drop_cnt_o
);

  logic capture;
  logic drop;

  // Only an empty register takes a new error
  assign capture = error_i.valid && !err_o.valid;
  assign drop    = error_i.valid && err_o.valid;

  // Payload follows every capture, valid is cleared by the acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o.valid <= 1'b0;
      err_o.code  <= ErrNone;
      err_o.info  <= '0;
    end else begin
      if (capture) begin
        err_o.code <= error_i.code;
        err_o.info <= error_i.info;
      end
      if (err_processed_i) begin
        err_o.valid <= 1'b0;
      end else if (capture) begin
        err_o.valid <= 1'b1;
      end
    end
  end

  // Saturating drop counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_drop_cnt_o <= '0;
    end else if (drop && (err_drop_cnt_o != 4'hF)) begin
      err_drop_cnt_o <= err_drop_cnt_o + 4'd1;
    end
  end

  HoldUntilAck_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (err_o.valid && !err_processed_i) |=> $stable(err_o))
    else $error("Held error changed without acknowledge");

endmodule : kmac_err_reg

// ==== kmac_errchk_top.sv ====
/*
  KMAC error checking subsystem
  Joins the command checker, the round controller that models the
  permutation, and the software-visible error register
*/
module kmac_errchk_top
  import kmac_pkg::*;
#(
  parameter bit EnMasking = 1'b1,
  parameter int NumRounds = 24
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  sha3_mode_e       cfg_mode_i,
  input  keccak_strength_e cfg_strength_i,
  input  logic             kmac_en_i,
  input  prefix_t          cfg_prefix_i,
  input  logic             cfg_en_unsupported_modestrength_i,
  input  logic             entropy_ready_pulse_i,
  input  kmac_cmd_e        sw_cmd_i,
  input  logic             app_active_i,
  input  logic             escalate_i,
  input  logic             err_processed_i,
  input  logic             clear_after_error_i,

  output err_t             err_o,
  output logic [3:0]       err_drop_cnt_o,
  output kmac_cmd_e        sw_cmd_o,
  output logic             absorbed_o,
  output logic             done_o,
  output logic             sparse_fsm_error_o
);

  // Raw error from the checker, before capture
  err_t error;

  kmac_errchk #(
    .EnMasking (EnMasking)
  ) u_errchk (
    .clk_i,
    .rst_ni,
    .cfg_mode_i,
    .cfg_strength_i,
    .kmac_en_i,
    .cfg_prefix_i,
    .cfg_en_unsupported_modestrength_i,
    .entropy_ready_pulse_i,
    .sw_cmd_i,
    .sw_cmd_o,
    .app_active_i,
    .absorbed_i          (absorbed_o),
    .keccak_done_i       (done_o),
    .escalate_i,
    .err_processed_i,
    .clear_after_error_i,
    .error_o             (error),
    .sparse_fsm_error_o
  );

  // Runs off the filtered command
  sha3_round_ctrl #(
    .NumRounds (NumRounds)
  ) u_round_ctrl (
    .clk_i,
    .rst_ni,
    .sw_cmd_i   (sw_cmd_o),
    .absorbed_o,
    .done_o
  );

  kmac_err_reg u_err_reg (
    .clk_i,
    .rst_ni,
    .error_i         (error),
    .err_processed_i,
    .err_o,
    .err_drop_cnt_o
  );

endmodule : kmac_errchk_top

// ==== tb_kmac_errchk.sv ====
/*
  KMAC error checker testbench
  Walks a table of software commands and configurations through the
  subsystem and checks the captured error, the forwarded command, the
  drop counter and the FSM error flag after each row
*/
module tb_kmac_errchk
  import kmac_pkg::*;
();

  localparam int NumRounds     = 4;
  localparam int NumRows       = 19;
  localparam int TimeoutCycles = NumRows * (NumRounds + 4);

  // encode_string("KMAC"), left_encode(32) = 01 20 then K M A C, first byte lowest
  localparam prefix_t KmacPrefix = {8'h43, 8'h41, 8'h4D, 8'h4B, 8'h20, 8'h01};

  // Per-row stimulus flags
  typedef logic [6:0] stim_flags_t;
  localparam stim_flags_t FKmac    = 7'h01;
  localparam stim_flags_t FRndPfx  = 7'h02;
  localparam stim_flags_t FPermit  = 7'h04;
  localparam stim_flags_t FEntropy = 7'h08;
  localparam stim_flags_t FAck     = 7'h10;
  localparam stim_flags_t FClear   = 7'h20;
  localparam stim_flags_t FEsc     = 7'h40;

  // Pulse to wait for after a row
  localparam logic [1:0] WaitNone     = 2'd0;
  localparam logic [1:0] WaitAbsorbed = 2'd1;
  localparam logic [1:0] WaitDone     = 2'd2;

  typedef struct packed {
    kmac_cmd_e        cmd;
    sha3_mode_e       mode;
    keccak_strength_e strength;
    stim_flags_t      flags;
    logic [1:0]       wait_sel;
    err_code_e        exp_code;
    err_info_t        exp_info;
    kmac_cmd_e        exp_cmd;
    logic [3:0]       exp_drop;
    logic             exp_fsm;
  } row_t;

  logic             clk_i;
  logic             rst_ni;
  sha3_mode_e       cfg_mode_i;
  keccak_strength_e cfg_strength_i;
  logic             kmac_en_i;
  prefix_t          cfg_prefix_i;
  logic             cfg_en_unsupported_modestrength_i;
  logic             entropy_ready_pulse_i;
  kmac_cmd_e        sw_cmd_i;
  logic             app_active_i;
  logic             escalate_i;
  logic             err_processed_i;
  logic             clear_after_error_i;
  err_t             err_o;
  logic [3:0]       err_drop_cnt_o;
  kmac_cmd_e        sw_cmd_o;
  logic             absorbed_o;
  logic             done_o;
  logic             sparse_fsm_error_o;

  row_t        rows [NumRows];
  int          num_rows;
  int          err_cnt;
  int          cycle_cnt;
  int          wait_cnt;
  logic [31:0] lfsr;
  prefix_t     rnd_prefix;

  kmac_errchk_top #(
    .EnMasking (1'b1),
    .NumRounds (NumRounds)
  ) i_dut (
    .clk_i                             (clk_i),
    .rst_ni                            (rst_ni),
    .cfg_mode_i                        (cfg_mode_i),
    .cfg_strength_i                    (cfg_strength_i),
    .kmac_en_i                         (kmac_en_i),
    .cfg_prefix_i                      (cfg_prefix_i),
    .cfg_en_unsupported_modestrength_i (cfg_en_unsupported_modestrength_i),
    .entropy_ready_pulse_i             (entropy_ready_pulse_i),
    .sw_cmd_i                          (sw_cmd_i),
    .app_active_i                      (app_active_i),
    .escalate_i                        (escalate_i),
    .err_processed_i                   (err_processed_i),
    .clear_after_error_i               (clear_after_error_i),
    .err_o                             (err_o),
    .err_drop_cnt_o                    (err_drop_cnt_o),
    .sw_cmd_o                          (sw_cmd_o),
    .absorbed_o                        (absorbed_o),
    .done_o                            (done_o),
    .sparse_fsm_error_o                (sparse_fsm_error_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Right-shifting Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[0];
    s  = s >> 1;
    if (fb)
      s = s ^ 32'hA300_0000;
    return s;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic add_row(input kmac_cmd_e cmd, input sha3_mode_e mode,
                         input keccak_strength_e strength, input stim_flags_t flags,
                         input logic [1:0] wait_sel, input err_code_e exp_code,
                         input err_info_t exp_info, input kmac_cmd_e exp_cmd,
                         input logic [3:0] exp_drop, input logic exp_fsm);
    rows[num_rows] = '{cmd, mode, strength, flags, wait_sel, exp_code, exp_info,
                       exp_cmd, exp_drop, exp_fsm};
    num_rows++;
  endtask

  task automatic apply_row(input row_t r);
    sw_cmd_i                          = r.cmd;
    cfg_mode_i                        = r.mode;
    cfg_strength_i                    = r.strength;
    kmac_en_i                         = |(r.flags & FKmac);
    cfg_prefix_i                      = |(r.flags & FRndPfx) ? rnd_prefix : KmacPrefix;
    cfg_en_unsupported_modestrength_i = |(r.flags & FPermit);
    entropy_ready_pulse_i             = |(r.flags & FEntropy);
    err_processed_i                   = |(r.flags & FAck);
    clear_after_error_i               = |(r.flags & FClear);
    escalate_i                        = |(r.flags & FEsc);
  endtask

  // Strobes last one cycle, configuration stays
  task automatic release_strobes();
    sw_cmd_i              = CmdNone;
    entropy_ready_pulse_i = 1'b0;
    err_processed_i       = 1'b0;
    clear_after_error_i   = 1'b0;
    escalate_i            = 1'b0;
  endtask

  task automatic check_row(input int idx, input row_t r);
    compare_value($sformatf("row %0d err_o.valid", idx), err_o.valid, r.exp_code != ErrNone);
    if (r.exp_code != ErrNone) begin
      compare_value($sformatf("row %0d err_o.code", idx), err_o.code, r.exp_code);
      compare_value($sformatf("row %0d err_o.info", idx), err_o.info, r.exp_info);
    end
    compare_value($sformatf("row %0d sw_cmd_o", idx), sw_cmd_o, r.exp_cmd);
    compare_value($sformatf("row %0d err_drop_cnt_o", idx), err_drop_cnt_o, r.exp_drop);
    compare_value($sformatf("row %0d sparse_fsm_error_o", idx), sparse_fsm_error_o, r.exp_fsm);
    // No round pulse outside a wait
    compare_value($sformatf("row %0d absorbed_o", idx), absorbed_o, 1'b0);
    compare_value($sformatf("row %0d done_o", idx), done_o, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout, no absorbed or done pulse within %0d cycles", TimeoutCycles);
    $display("TEST FAIL");
    $fatal(1, "Timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    num_rows = 0;
    err_cnt  = 0;
    wait_cnt = 0;
    rst_ni   = 1'b0;
    app_active_i = 1'b0;
    apply_row('{CmdNone, Sha3, L256, '0, WaitNone, ErrNone, '0, CmdNone, 4'd0, 1'b0});

    // Random wrong prefix, never the real one
    lfsr = 32'h1ff9_2d79;
    for (int b = 0; b < 48; b++) begin
      lfsr          = lfsr_step(lfsr);
      rnd_prefix[b] = lfsr[0];
    end
    if (rnd_prefix == KmacPrefix)
      rnd_prefix[0] = ~rnd_prefix[0];

    // Legal sequence
    add_row(CmdNone, Sha3, L256, FEntropy, WaitNone, ErrNone, 24'h0, CmdNone, 0, 0);
    add_row(CmdStart, Sha3, L256, '0, WaitNone, ErrNone, 24'h0, CmdStart, 0, 0);
    add_row(CmdProcess, Sha3, L256, '0, WaitAbsorbed, ErrNone, 24'h0, CmdProcess, 0, 0);
    add_row(CmdManualRun, Sha3, L256, '0, WaitDone, ErrNone, 24'h0, CmdManualRun, 0, 0);
    add_row(CmdDone, Sha3, L256, '0, WaitNone, ErrNone, 24'h0, CmdDone, 0, 0);
    // Process in Idle, blocked
    add_row(CmdProcess, Sha3, L256, '0, WaitNone, ErrSwCmdSequence, 24'h04002E, CmdNone, 0, 0);
    add_row(CmdNone, Sha3, L256, FAck, WaitNone, ErrNone, 24'h0, CmdNone, 0, 0);
    // Shake with L512, blocked then permitted
    add_row(CmdStart, Shake, L512, '0, WaitNone, ErrUnexpectedModeStrength,
            24'h020024, CmdNone, 0, 0);
    add_row(CmdNone, Sha3, L256, FAck, WaitNone, ErrNone, 24'h0, CmdNone, 0, 0);
    add_row(CmdStart, Shake, L512, FPermit, WaitNone, ErrUnexpectedModeStrength,
            24'h020024, CmdStart, 0, 0);
    add_row(CmdNone, Sha3, L256, FAck | FClear, WaitNone, ErrNone, 24'h0, CmdNone, 0, 0);
    // KMAC with a wrong prefix goes through
    add_row(CmdNone, Sha3, L256, FEntropy, WaitNone, ErrNone, 24'h0, CmdNone, 0, 0);
    add_row(CmdStart, Sha3, L256, FKmac | FRndPfx, WaitNone, ErrIncorrectFunctionName,
            24'h010000, CmdStart, 0, 0);
    add_row(CmdNone, Sha3, L256, FAck | FClear, WaitNone, ErrNone, 24'h0, CmdNone, 0, 0);
    // KMAC without entropy, then a dropped second error
    add_row(CmdStart, Sha3, L256, FKmac, WaitNone, ErrSwHashingWithoutEntropyReady,
            24'h080002, CmdNone, 0, 0);
    add_row(CmdProcess, Sha3, L256, '0, WaitNone, ErrSwHashingWithoutEntropyReady,
            24'h080002, CmdNone, 1, 0);
    add_row(CmdNone, Sha3, L256, FAck, WaitNone, ErrNone, 24'h0, CmdNone, 1, 0);
    // Escalation is sticky
    add_row(CmdNone, Sha3, L256, FEsc, WaitNone, ErrNone, 24'h0, CmdNone, 1, 1);
    add_row(CmdNone, Sha3, L256, FClear, WaitNone, ErrNone, 24'h0, CmdNone, 1, 1);

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    compare_value("reset sw_cmd_o", sw_cmd_o, CmdNone);
    compare_value("reset err_o.valid", err_o.valid, 1'b0);
    compare_value("reset sparse_fsm_error_o", sparse_fsm_error_o, 1'b0);

    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk_i);
      #1;
      apply_row(rows[i]);
      @(posedge clk_i);
      #1;
      release_strobes();
      check_row(i, rows[i]);
      wait_cnt = 0;
      if (rows[i].wait_sel == WaitAbsorbed) begin
        while (!absorbed_o) begin
          @(posedge clk_i);
          #1;
          wait_cnt++;
        end
      end else if (rows[i].wait_sel == WaitDone) begin
        while (!done_o) begin
          @(posedge clk_i);
          #1;
          wait_cnt++;
        end
      end
      if (rows[i].wait_sel != WaitNone) begin
        // Rounds start one cycle after sw_cmd_o shows the command
        compare_value($sformatf("row %0d pulse delay", i), wait_cnt, NumRounds + 1);
        compare_value($sformatf("row %0d absorbed_o", i), absorbed_o,
                      rows[i].wait_sel == WaitAbsorbed);
        compare_value($sformatf("row %0d done_o", i), done_o,
                      rows[i].wait_sel == WaitDone);
      end
    end

    if (err_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "Run ended with errors");
    end
  end

endmodule : tb_kmac_errchk

// ==== filelist.f ====
kmac_pkg.sv
kmac_errchk.sv
sha3_round_ctrl.sv
kmac_err_reg.sv
kmac_errchk_top.sv
tb_kmac_errchk.sv
